/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f vlog.f --top-module l2_mem_path_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

out=$(./obj_dir/Vl2_mem_path_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '** PASS **'; then
	exit 0
fi
echo "Pass message not found in the simulation output."
exit 1

/* verification/l2_mem_path_tb.sv */
`timescale 1ns/1ns
`include "vc_macros.svh"

// Testbench for the memory-side path below L2.
// It plays the L2 cache from a stimulus table and models physical memory.
module l2_mem_path_tb
	import vc_pkg::*;
();

	localparam int HALF_PERIOD   = 20; // 40 ns clock period.
	localparam int RESET_CYCLES  = 5;
	localparam int CYCLES_PER_OP = 30; // Generous bound for one request with a slow memory.

	logic  pmembus;
	logic  rst_n;
	logic  l2_stb, l2_we, l2_dirty;
	addr_t l2_adr;
	line_t l2_dat_m;
	logic  pmem_ack;
	line_t pmem_dat_s;
	logic  l2_ack;
	line_t l2_dat_s;
	logic  pmem_stb, pmem_cyc, pmem_we;
	addr_t pmem_adr;
	line_t pmem_dat_m;

	// Stimulus table, one entry per operation line of the stim file.
	logic  op_we [$];
	addr_t op_adr [$];
	line_t op_dat [$];
	logic  op_dirty [$];
	logic  exp_mem [$];   // Memory request expected for this operation.
	addr_t exp_adr [$];
	line_t exp_line [$];  // Returned line for reads, written-back line for writes.

	// Memory requests seen while the current operation runs.
	addr_t rd_adr [$];
	addr_t wr_adr [$];
	line_t wr_dat [$];
	time   wr_time [$];

	int cycles      = 0;
	int cycle_limit = 0;  // Stays zero until the table is loaded.
	int mem_lat;          // Acknowledge latency of the next memory request.

	l2_mem_path i_l2_mem_path
	(
		.pmembus, .rst_n,
		.l2_stb, .l2_we, .l2_adr, .l2_dat_m, .l2_dirty,
		.pmem_ack, .pmem_dat_s,
		.l2_ack, .l2_dat_s,
		.pmem_stb, .pmem_cyc, .pmem_we, .pmem_adr, .pmem_dat_m
	);

	initial
	begin
		pmembus = 1'b0;
		forever #HALF_PERIOD pmembus = ~pmembus;
	end

	// ------------------------------------------------------------
	// Failure reporting and compare tasks.
	// ------------------------------------------------------------

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_line(input string name, input line_t exp, input line_t act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: %s expected %b, got %b",
				$time, name, exp, act));
	endtask

	// ------------------------------------------------------------
	// Memory model.
	// ------------------------------------------------------------

	// Each 32-bit word of a memory line holds the address XORed with a fixed pattern.
	function automatic line_t mem_line_for(input addr_t adr);
		logic [31:0] word;
		word = {20'h0, adr} ^ 32'hA5A5_A5A5;
		return {(`LINE_BITS/32){word}};
	endfunction

	// Requests are sampled on the rising edge, the acknowledge is driven on the falling one.
	initial
	begin : memory_model
		int    waited;
		logic  raise;
		addr_t adr_s;
		waited     = 0;
		pmem_ack   = 1'b0;
		pmem_dat_s = '0;
		forever
		begin
			@(posedge pmembus);
			raise = 1'b0;
			adr_s = pmem_adr;
			if (rst_n)
				check_flag("pmem_cyc", pmem_stb, pmem_cyc); // Cycle always follows strobe.
			if (pmem_stb && pmem_ack)
			begin
				// Handshake completes on this edge, so log the request.
				if (pmem_we)
				begin
					wr_adr.push_back(pmem_adr);
					wr_dat.push_back(pmem_dat_m);
					wr_time.push_back($time);
				end
				else
					rd_adr.push_back(pmem_adr);
				waited = 0;
			end
			else if (pmem_stb)
			begin
				waited++;
				raise = (waited >= mem_lat);
			end
			@(negedge pmembus);
			pmem_ack   = raise; // One-cycle pulse.
			pmem_dat_s = raise ? mem_line_for(adr_s) : '0;
			if (raise)
				mem_lat = $urandom_range(4, 1);
		end
	end

	// ------------------------------------------------------------
	// Stimulus and L2 driver.
	// ------------------------------------------------------------

	task automatic load_stim();
		int    fd;
		int    n;
		string text;
		byte   op_c;
		addr_t a, ea;
		line_t d, el;
		logic  dirty, flag;
		fd = $fopen("verification/l2_mem_stim.txt", "r");
		if (fd == 0)
			abort_run("Cannot open the stimulus file verification/l2_mem_stim.txt.");
		while ($fgets(text, fd) != 0)
		begin
			if (text.len() < 2 || text.getc(0) == "#")
				continue; // Header comments and blank lines.
			n = $sscanf(text, "%c %h %h %h %h %h %h", op_c, a, d, dirty, flag, ea, el);
			if (n != 7 || (op_c != "R" && op_c != "W"))
				abort_run({"Malformed stimulus line: ", text});
			op_we.push_back(op_c == "W");
			op_adr.push_back(a);
			op_dat.push_back(d);
			op_dirty.push_back(dirty);
			exp_mem.push_back(flag);
			exp_adr.push_back(ea);
			exp_line.push_back(el);
		end
		$fclose(fd);
		if (op_we.size() == 0)
			abort_run("The stimulus file holds no operations.");
	endtask

	// Runs one L2 request from a falling edge and checks it once the strobe drops.
	task automatic run_op(input int i);
		time   ack_time;
		line_t got;
		int    n_mem;
		rd_adr.delete();
		wr_adr.delete();
		wr_dat.delete();
		wr_time.delete();
		l2_stb   = 1'b1;
		l2_we    = op_we[i];
		l2_adr   = op_adr[i];
		l2_dat_m = op_dat[i];
		l2_dirty = op_dirty[i];
		do
			@(posedge pmembus);
		while (l2_ack !== 1'b1);
		ack_time = $time;
		got      = l2_dat_s;   // Valid in the acknowledge cycle only.
		@(negedge pmembus);
		l2_stb = 1'b0;
		n_mem  = rd_adr.size() + wr_adr.size();
		if (n_mem != int'(exp_mem[i]))
			abort_run($sformatf("Operation %0d: memory saw %0d requests instead of %0d.",
				i, n_mem, exp_mem[i]));
		if (op_we[i])
		begin
			check_flag("pmem_we", exp_mem[i], wr_adr.size() != 0);
			if (exp_mem[i])
			begin
				check_addr("pmem_adr", exp_adr[i], wr_adr[0]);
				check_line("pmem_dat_m", exp_line[i], wr_dat[0]);
				check_flag("l2_ack after writeback", 1'b1, wr_time[0] < ack_time);
			end
		end
		else
		begin
			check_line("l2_dat_s", exp_line[i], got);
			check_flag("pmem_stb", exp_mem[i], rd_adr.size() != 0);
			if (exp_mem[i])
				check_addr("pmem_adr", exp_adr[i], rd_adr[0]);
		end
	endtask

	initial
	begin : l2_driver
		void'($urandom(6575)); // Seeds the run.
		mem_lat  = $urandom_range(4, 1);
		rst_n    = 1'b0;
		l2_stb   = 1'b0;
		l2_we    = 1'b0;
		l2_adr   = '0;
		l2_dat_m = '0;
		l2_dirty = 1'b0;
		load_stim();
		cycle_limit = CYCLES_PER_OP * op_we.size() + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge pmembus);
		@(negedge pmembus);
		rst_n = 1'b1;
		// Nothing may be pending straight out of reset.
		check_flag("l2_ack", 1'b0, l2_ack);
		check_flag("pmem_stb", 1'b0, pmem_stb);
		check_flag("pmem_we", 1'b0, pmem_we);
		for (int i = 0; i < op_we.size(); i++)
			run_op(i);
		$display("** PASS **");
		$finish;
	end

	always @(posedge pmembus)
	begin
		cycles++;
		if (cycle_limit != 0 && cycles >= cycle_limit)
			abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles.",
				cycle_limit));
	end

endmodule : l2_mem_path_tb

/* verification/l2_mem_stim.txt */
# op adr line dirty | mem_flag mem_adr mem_line, all hex. R: flag = memory read, line = returned.
# W: flag = writeback, with its address and line. Memory word = {20'h0, adr} ^ 32'hA5A5A5A5.
R 100 0 0 1 100 A5A5A4A5A5A5A4A5A5A5A4A5A5A5A4A5
W 200 0200C0DE0200C0DE0200C0DE0200C0DE 1 0 000 0
R 200 0 0 0 000 0200C0DE0200C0DE0200C0DE0200C0DE
R 200 0 0 1 200 A5A5A7A5A5A5A7A5A5A5A7A5A5A5A7A5
W 410 0410F00D0410F00D0410F00D0410F00D 0 0 000 0
W 420 0420F00D0420F00D0420F00D0420F00D 0 0 000 0
W 430 0430F00D0430F00D0430F00D0430F00D 0 0 000 0
W 440 0440F00D0440F00D0440F00D0440F00D 0 0 000 0
W 450 0450F00D0450F00D0450F00D0450F00D 0 0 000 0
W 510 0510C0DE0510C0DE0510C0DE0510C0DE 1 0 000 0
W 520 0520C0DE0520C0DE0520C0DE0520C0DE 1 0 000 0
W 530 0530C0DE0530C0DE0530C0DE0530C0DE 1 0 000 0
W 540 0540C0DE0540C0DE0540C0DE0540C0DE 1 0 000 0
W 550 0550C0DE0550C0DE0550C0DE0550C0DE 1 1 510 0510C0DE0510C0DE0510C0DE0510C0DE
R 530 0 0 0 000 0530C0DE0530C0DE0530C0DE0530C0DE
W 560 0560F00D0560F00D0560F00D0560F00D 0 0 000 0
W 570 0570C0DE0570C0DE0570C0DE0570C0DE 1 0 000 0
W 580 0580C0DE0580C0DE0580C0DE0580C0DE 1 1 540 0540C0DE0540C0DE0540C0DE0540C0DE
R 700 0 0 1 700 A5A5A2A5A5A5A2A5A5A5A2A5A5A5A2A5
R 550 0 0 0 000 0550C0DE0550C0DE0550C0DE0550C0DE
R 520 0 0 0 000 0520C0DE0520C0DE0520C0DE0520C0DE
W 590 0590F00D0590F00D0590F00D0590F00D 0 0 000 0
R 510 0 0 1 510 A5A5A0B5A5A5A0B5A5A5A0B5A5A5A0B5
W 5A0 05A0C0DE05A0C0DE05A0C0DE05A0C0DE 1 0 000 0
W 5B0 05B0C0DE05B0C0DE05B0C0DE05B0C0DE 1 1 570 0570C0DE0570C0DE0570C0DE0570C0DE
R 590 0 0 0 000 0590F00D0590F00D0590F00D0590F00D

/* verilog/entry_ram.sv */
`timescale 1ns/1ns
`include "vc_macros.svh"

// Small register file with one write port and one asynchronous read port.
// The payload type is a parameter, so the same block holds tags or lines.
module entry_ram
	import vc_pkg::*;
#(
	parameter type payload_t = line_t,
	parameter int  depth     = `VC_ENTRIES
)
(
	input  logic     pmembus,
	input  logic     rst_n,
	input  logic     we,
	input  vc_idx_t  waddr,
	input  payload_t wdata,
	input  vc_idx_t  raddr,
	output payload_t rdata
);

	payload_t mem [depth]; // Storage words.

	// Reset clears every word, so all tags start out invalid.
	always_ff @(posedge pmembus or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < depth; i++)
				mem[i] <= '0;
		end
		else if (we)
			mem[waddr] <= wdata; // Single write per clock.
	end

	assign rdata = mem[raddr]; // Read is combinational.

endmodule : entry_ram

/* verilog/l2_mem_path.sv */
`timescale 1ns/1ns

// Memory-side path below the L2 cache.
// Connects the victim cache and the steering block to the L2 and memory ports.
module l2_mem_path
	import vc_pkg::*;
(
	input  logic  pmembus,
	input  logic  rst_n,
	input  logic  l2_stb,
	input  logic  l2_we,
	input  addr_t l2_adr,
	input  line_t l2_dat_m,
	input  logic  l2_dirty,
	input  logic  pmem_ack,
	input  line_t pmem_dat_s,
	output logic  l2_ack,
	output line_t l2_dat_s,
	output logic  pmem_stb,
	output logic  pmem_cyc,
	output logic  pmem_we,
	output addr_t pmem_adr,
	output line_t pmem_dat_m
);

	logic  vc_read, vc_write; // Gated L2 strobes into the victim cache.
	logic  vc_ack, vc_miss;
	line_t vc_dat;
	logic  wb_stb;            // Victim writeback in progress.
	addr_t wb_adr;
	line_t wb_dat;

	victim_cache i_victim_cache
	(
		.pmembus, .rst_n,
		.vc_read, .vc_write,
		.l2_adr, .l2_dat_m, .l2_dirty,
		.pmem_ack,
		.vc_ack, .vc_miss, .vc_dat,
		.wb_stb, .wb_adr, .wb_dat
	);

	mem_steer i_mem_steer
	(
		.pmembus, .rst_n,
		.l2_stb, .l2_we, .l2_adr,
		.vc_ack, .vc_miss, .vc_dat,
		.wb_stb, .wb_adr, .wb_dat,
		.pmem_ack, .pmem_dat_s,
		.vc_read, .vc_write,
		.l2_ack, .l2_dat_s,
		.pmem_stb, .pmem_cyc, .pmem_we, .pmem_adr, .pmem_dat_m
	);

endmodule : l2_mem_path

/* verilog/mem_steer.sv */
`timescale 1ns/1ns

// Steers L2 traffic between the victim cache and physical memory.
// A one-bit owner decides where reads, acknowledges and data come from.
module mem_steer
	import vc_pkg::*;
(
	input  logic  pmembus,
	input  logic  rst_n,
	input  logic  l2_stb,
	input  logic  l2_we,
	input  addr_t l2_adr,
	input  logic  vc_ack,
	input  logic  vc_miss,
	input  line_t vc_dat,
	input  logic  wb_stb,
	input  addr_t wb_adr,
	input  line_t wb_dat,
	input  logic  pmem_ack,
	input  line_t pmem_dat_s,
	output logic  vc_read,
	output logic  vc_write,
	output logic  l2_ack,
	output line_t l2_dat_s,
	output logic  pmem_stb,
	output logic  pmem_cyc,
	output logic  pmem_we,
	output addr_t pmem_adr,
	output line_t pmem_dat_m
);

	owner_t owner;   // Current answerer of L2 reads.
	logic   rd_req;  // L2 wants a line.
	logic   pmem_rd; // Read handed over to memory.

	// ------------------------------------------------------------
	// Owner state.
	// ------------------------------------------------------------

	// A miss hands the read to memory.
	// The memory acknowledge ends it and gives control back.
	always_ff @(posedge pmembus or negedge rst_n)
	begin
		if (!rst_n)
			owner <= OWN_VICTIM;
		else if (owner == OWN_VICTIM && vc_miss)
			owner <= OWN_PMEM;
		else if (owner == OWN_PMEM && pmem_ack)
			owner <= OWN_VICTIM;
	end

	// ------------------------------------------------------------
	// Request and response routing.
	// ------------------------------------------------------------

	assign rd_req   = l2_stb && !l2_we;
	assign vc_read  = rd_req && (owner == OWN_VICTIM);
	assign pmem_rd  = rd_req && (owner == OWN_PMEM);
	assign vc_write = l2_stb && l2_we; // Evictions always go to the victim cache.

	// Memory answers only while it owns the read.
	// A writeback acknowledge stays inside the victim cache.
	assign l2_ack   = (owner == OWN_PMEM) ? pmem_ack : vc_ack;
	assign l2_dat_s = (owner == OWN_PMEM) ? pmem_dat_s : vc_dat;

	// Reads and writebacks never overlap, one L2 request is open at a time.
	assign pmem_stb   = pmem_rd || wb_stb;
	assign pmem_cyc   = pmem_stb;
	assign pmem_we    = wb_stb;
	assign pmem_adr   = wb_stb ? wb_adr : l2_adr;
	assign pmem_dat_m = wb_dat; // Only a writeback carries data out.

endmodule : mem_steer

/* verilog/vc_macros.svh */
`ifndef VC_MACROS_SVH
`define VC_MACROS_SVH

// ------------------------------------------------------------
// Sizes of the memory-side path below the L2 cache.
// ------------------------------------------------------------

// Width of a line address as seen by L2 and by physical memory.
`define ADDR_BITS 12

// One cache line moves as a single 128-bit beat.
`define LINE_BITS 128

// Number of lines held by the victim cache.
`define VC_ENTRIES 4

// Width of an index into the victim entries, log2 of VC_ENTRIES.
`define VC_IDX_BITS 2

`endif

/* verilog/vc_pkg.sv */
`include "vc_macros.svh"

package vc_pkg;

	// ------------------------------------------------------------
	// Payload types shared by the victim cache and the steering.
	// ------------------------------------------------------------

	// A line address, one per 128-bit line.
	typedef logic [`ADDR_BITS-1:0] addr_t;

	// One whole cache line.
	typedef logic [`LINE_BITS-1:0] line_t;

	// Selects one of the victim entries.
	typedef logic [`VC_IDX_BITS-1:0] vc_idx_t;

	// Tag word of one victim entry.
	// An all-zero word is an empty entry, which is what reset leaves behind.
	typedef struct packed
	{
		logic  valid; // Entry holds a line.
		logic  dirty; // Line differs from memory and must be written back.
		addr_t adr;   // Line address of the held line.
	} vc_tag_t;

	// Who answers L2 reads at the moment.
	// The victim cache owns the path until a lookup misses.
	// Memory then owns it until it acknowledges the read.
	typedef enum logic
	{
		OWN_VICTIM = 1'b0,
		OWN_PMEM   = 1'b1
	} owner_t;

endpackage : vc_pkg

/* verilog/victim_cache.sv */
`timescale 1ns/1ns
`include "vc_macros.svh"

// Victim cache below L2.
// Holds evicted lines, returns them on a later L2 read and writes dirty
// lines back to memory when they are pushed out.
module victim_cache
	import vc_pkg::*;
(
	input  logic    pmembus,
	input  logic    rst_n,
	input  logic    vc_read,
	input  logic    vc_write,
	input  addr_t   l2_adr,
	input  line_t   l2_dat_m,
	input  logic    l2_dirty,
	input  logic    pmem_ack,
	output logic    vc_ack,
	output logic    vc_miss,
	output line_t   vc_dat,
	output logic    wb_stb,
	output addr_t   wb_adr,
	output line_t   wb_dat
);

	// Request phases. RESP answers a read, WB waits on memory, FILL stores.
	typedef enum logic [1:0] {S_IDLE, S_RESP, S_WB, S_FILL} vc_state_t;

	vc_state_t state;
	vc_idx_t   idx_r;                   // Entry picked when the request was taken.
	logic      hit_r;                   // Registered lookup result.
	vc_idx_t   rr_ptr;                  // Round-robin replacement pointer.
	logic [`VC_ENTRIES-1:0] vld;        // Per-entry valid bits for the compare.
	addr_t     cam_adr [`VC_ENTRIES];   // Address copy used for the parallel match.

	logic      hit;
	vc_idx_t   hit_idx;
	vc_idx_t   pick_idx;
	vc_idx_t   raddr;
	logic      tag_we;
	vc_tag_t   tag_wd;
	vc_tag_t   tag_rd;
	line_t     line_rd;

	// ------------------------------------------------------------
	// Lookup and entry choice.
	// ------------------------------------------------------------

	// Compare the L2 address against every valid entry at once.
	always_comb
	begin
		hit     = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < `VC_ENTRIES; i++)
		begin
			if (vld[i] && cam_adr[i] == l2_adr)
			begin
				hit     = 1'b1;
				hit_idx = vc_idx_t'(i);
			end
		end
	end

	// Lowest free entry wins; with none free the pointer picks the victim.
	always_comb
	begin
		pick_idx = rr_ptr;
		for (int i = `VC_ENTRIES-1; i >= 0; i--)
		begin
			if (!vld[i])
				pick_idx = vc_idx_t'(i);
		end
	end

	// While idle the read port looks at the write candidate.
	// Afterwards it stays on the entry that the request was bound to.
	assign raddr = (state == S_IDLE) ? pick_idx : idx_r;

	// ------------------------------------------------------------
	// Entry storage.
	// ------------------------------------------------------------

	// A hit frees its entry; a fill stores the new tag.
	assign tag_we = (state == S_FILL) || (state == S_RESP && hit_r);
	assign tag_wd = (state == S_FILL)
		? vc_tag_t'{valid: 1'b1, dirty: l2_dirty, adr: l2_adr}
		: '0;

	entry_ram #(.payload_t(vc_tag_t), .depth(`VC_ENTRIES)) i_tag_ram
	(
		.pmembus, .rst_n,
		.we(tag_we), .waddr(idx_r), .wdata(tag_wd),
		.raddr, .rdata(tag_rd)
	);

	entry_ram #(.payload_t(line_t), .depth(`VC_ENTRIES)) i_line_ram
	(
		.pmembus, .rst_n,
		.we(state == S_FILL), .waddr(idx_r), .wdata(l2_dat_m),
		.raddr, .rdata(line_rd)
	);

	// ------------------------------------------------------------
	// Request sequencing.
	// ------------------------------------------------------------

	always_ff @(posedge pmembus or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state  <= S_IDLE;
			idx_r  <= '0;
			hit_r  <= 1'b0;
			rr_ptr <= '0;
			vld    <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (vc_write)
					begin
						idx_r <= pick_idx;
						// A dirty line in the way has to reach memory first.
						state <= (tag_rd.valid && tag_rd.dirty) ? S_WB : S_FILL;
					end
					else if (vc_read)
					begin
						hit_r <= hit;
						idx_r <= hit_idx;
						state <= S_RESP;
					end
				end
				S_RESP:
				begin
					if (hit_r)
						vld[idx_r] <= 1'b0; // The line moves back into L2.
					state <= S_IDLE;
				end
				S_WB:
				begin
					if (pmem_ack)
						state <= S_FILL; // The slot is free once the writeback is done.
				end
				default:
				begin
					vld[idx_r] <= 1'b1;
					rr_ptr     <= rr_ptr + 1'b1;
					state      <= S_IDLE;
				end
			endcase
		end
	end

	// Each fill also loads the address copy that the parallel match uses.
	always_ff @(posedge pmembus)
	begin
		if (state == S_FILL)
			cam_adr[idx_r] <= l2_adr;
	end

	// Outputs decode straight from the phase.
	assign vc_ack  = (state == S_FILL) || (state == S_RESP && hit_r);
	assign vc_miss = (state == S_RESP) && !hit_r; // One cycle, then memory takes over.
	assign vc_dat  = line_rd;
	assign wb_stb  = (state == S_WB);             // Held until memory acknowledges.
	assign wb_adr  = tag_rd.adr;
	assign wb_dat  = line_rd;

endmodule : victim_cache

/* vlog.f */
+incdir+verilog
verilog/vc_pkg.sv
verilog/entry_ram.sv
verilog/victim_cache.sv
verilog/mem_steer.sv
verilog/l2_mem_path.sv
verification/l2_mem_path_tb.sv
